// ==== Makefile ====
# Verilator simulation of the AHB master multiplexer

TOP = tb_ahb_master_mux

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module $(TOP) --Mdir obj_dir -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; \
		echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== bench/tb_ahb_master_mux.sv ====
/* Testbench for the three port AHB master multiplexer
   Random masters, a waited slave memory model and arbitration checks */
`timescale 1ns/1ps

module tb_ahb_master_mux;

  localparam int n_rand    = 40;
  // Three locked transfers plus the unlocking idle
  localparam int n_total   = 3 * n_rand + 4;
  localparam int max_cycle = 20 * n_total + 200;
  localparam logic [7:0] err_idx = 8'hff;

  logic                       HCLK;
  logic                       HRESETn;
  logic                       hsel_s[3];
  logic [31:0]                haddr_s[3];
  ahb_mux_pkg::htrans_t       htrans_s[3];
  logic [2:0]                 hsize_s[3];
  logic                       hwrite_s[3];
  logic                       hmastlock_s[3];
  logic [31:0]                hwdata_s[3];
  logic                       hreadyout_s[3];
  logic                       hresp_s[3];
  logic [31:0]                hrdata_s[3];
  logic                       hsel_m, hwrite_m, hready_m, hmastlock_m;
  logic [31:0]                haddr_m, hwdata_m, hrdata_m;
  ahb_mux_pkg::htrans_t       htrans_m;
  logic [2:0]                 hsize_m;
  ahb_mux_pkg::hmaster_t      hmaster;
  logic                       hreadyout_m, hresp_m;
  integer                     seed;
  int                         cycle;
  int                         chk_cnt[6];
  int                         err_cnt[6];
  string                      test_name[6];
  logic [31:0]                mem[256];
  // Issued writes, {port, word index, data}
  logic [41:0]                wr_q[$];

  always #2 HCLK = ~HCLK;

  // The master's HREADY is the mux's own HREADYOUT
  ahb_master_mux #(.data_width(32)) ahb_master_mux_inst (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .hsel_s0(hsel_s[0]), .haddr_s0(haddr_s[0]), .htrans_s0(htrans_s[0]),
    .hsize_s0(hsize_s[0]), .hwrite_s0(hwrite_s[0]), .hready_s0(hreadyout_s[0]),
    .hmastlock_s0(hmastlock_s[0]), .hwdata_s0(hwdata_s[0]),
    .hreadyout_s0(hreadyout_s[0]), .hresp_s0(hresp_s[0]), .hrdata_s0(hrdata_s[0]),
    .hsel_s1(hsel_s[1]), .haddr_s1(haddr_s[1]), .htrans_s1(htrans_s[1]),
    .hsize_s1(hsize_s[1]), .hwrite_s1(hwrite_s[1]), .hready_s1(hreadyout_s[1]),
    .hmastlock_s1(hmastlock_s[1]), .hwdata_s1(hwdata_s[1]),
    .hreadyout_s1(hreadyout_s[1]), .hresp_s1(hresp_s[1]), .hrdata_s1(hrdata_s[1]),
    .hsel_s2(hsel_s[2]), .haddr_s2(haddr_s[2]), .htrans_s2(htrans_s[2]),
    .hsize_s2(hsize_s[2]), .hwrite_s2(hwrite_s[2]), .hready_s2(hreadyout_s[2]),
    .hmastlock_s2(hmastlock_s[2]), .hwdata_s2(hwdata_s[2]),
    .hreadyout_s2(hreadyout_s[2]), .hresp_s2(hresp_s[2]), .hrdata_s2(hrdata_s[2]),
    .hsel_m(hsel_m), .haddr_m(haddr_m), .htrans_m(htrans_m), .hsize_m(hsize_m),
    .hwrite_m(hwrite_m), .hready_m(hready_m), .hmastlock_m(hmastlock_m),
    .hwdata_m(hwdata_m), .hmaster(hmaster), .hreadyout_m(hreadyout_m),
    .hresp_m(hresp_m), .hrdata_m(hrdata_m)
  );

  task automatic check(input int test, input string name, input logic [63:0] got,
                       input logic [63:0] exp);
    chk_cnt[test]++;
    if (got !== exp)
    begin
      err_cnt[test]++;
      $display("ERROR at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  // -------------------------------------------------------------------
  // Master side, one non pipelined transfer at a time
  // -------------------------------------------------------------------
  task automatic do_transfer(input int p, input bit wr, input logic [7:0] idx,
                             input bit lock);
    logic [31:0] wdata;
    wdata = $random(seed);
    @(negedge HCLK);
    hsel_s[p]      = 1'b1;
    haddr_s[p]     = {22'd0, idx, 2'b00};
    htrans_s[p]    = ahb_mux_pkg::trans_nonseq;
    hwrite_s[p]    = wr;
    hmastlock_s[p] = lock;
    // Address phase ends at the first edge with HREADY high
    do @(posedge HCLK); while (!hreadyout_s[p]);
    if (wr)
      wr_q.push_back({p[1:0], idx, wdata});
    @(negedge HCLK);
    // Locked idles keep the bus owned between transfers
    hsel_s[p]   = lock;
    htrans_s[p] = ahb_mux_pkg::trans_idle;
    hwdata_s[p] = wdata;
    do @(posedge HCLK); while (!hreadyout_s[p]);
    if (idx == err_idx)
      check(2, $sformatf("hresp_s%0d", p), hresp_s[p], 1'b1);
    else
    begin
      check(wr ? 1 : 2, $sformatf("hresp_s%0d", p), hresp_s[p], 1'b0);
      if (!wr)
        check(2, $sformatf("hrdata_s%0d", p), hrdata_s[p], mem[idx]);
    end
  endtask

  task automatic run_master(input int p);
    int          gap;
    bit          wr;
    logic [7:0]  idx;
    for (int n = 0; n < n_rand; n++)
    begin
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(negedge HCLK);
      wr  = $random(seed) & 1;
      idx = $random(seed);
      // Writes stay inside a private quarter of the memory
      if (wr)
        idx = {p[1:0], idx[5:0]};
      else if (idx[2:0] == 3'd0)
        idx = err_idx;
      do_transfer(p, wr, idx, 1'b0);
      // Port 0 runs its locked sequence in the middle of the traffic
      if (p == 0 && n == n_rand / 2)
      begin
        for (int k = 0; k < 3; k++)
          do_transfer(0, k[0], {2'b00, 6'd60 + 6'(k)}, 1'b1);
        @(negedge HCLK);
        hmastlock_s[0] = 1'b0;
        do @(posedge HCLK); while (!hreadyout_s[0]);
        @(negedge HCLK);
        hsel_s[0] = 1'b0;
      end
    end
  endtask

  // -------------------------------------------------------------------
  // Slave memory model with wait states and a two cycle ERROR
  // -------------------------------------------------------------------
  bit         dp_valid, dp_write, dp_err, err_phase;
  logic [7:0] dp_idx;
  int         dp_owner, wait_cnt;

  always @(posedge HCLK)
  begin
    int hit;
    if (!HRESETn)
    begin
      dp_valid = 0;
      dp_err   = 0;
    end
    else
    begin
      // Response goes to the data phase owner alone
      for (int i = 0; i < 3; i++)
        check(2, $sformatf("hresp_s%0d", i), hresp_s[i],
              dp_valid && dp_err && dp_owner == i);
      if (dp_valid && hreadyout_m)
      begin
        dp_valid = 0;
        if (dp_write && !dp_err)
        begin
          mem[dp_idx] = hwdata_m;
          hit = -1;
          for (int i = 0; i < wr_q.size(); i++)
            if (hit < 0 && wr_q[i][41:40] == dp_owner)
              hit = i;
          if (hit < 0)
          begin
            err_cnt[1]++;
            $display("Write from port %0d reached the slave but was never issued",
                     dp_owner);
          end
          else
          begin
            check(1, "write index", dp_idx, wr_q[hit][39:32]);
            check(1, "hwdata_m", hwdata_m, wr_q[hit][31:0]);
            wr_q.delete(hit);
          end
        end
      end
      else if (dp_valid)
      begin
        if (dp_err)
          err_phase = 1;
        else
          wait_cnt--;
      end
      if (hready_m && hsel_m && htrans_m == ahb_mux_pkg::trans_nonseq)
      begin
        // Every master issues word transfers
        check(hwrite_m ? 1 : 2, "hsize_m", hsize_m, 3'd2);
        dp_valid  = 1;
        dp_write  = hwrite_m;
        dp_idx    = haddr_m[9:2];
        dp_owner  = int'(hmaster);
        dp_err    = (haddr_m[9:2] == err_idx);
        err_phase = 0;
        wait_cnt  = $unsigned($random(seed)) % 3;
      end
    end
  end

  always @(negedge HCLK)
  begin
    hreadyout_m = !dp_valid || (dp_err ? err_phase : wait_cnt == 0);
    hresp_m     = dp_valid && dp_err;
    hrdata_m    = (dp_valid && !dp_write) ? mem[dp_idx] : 32'd0;
  end

  // -------------------------------------------------------------------
  // Arbitration monitor
  // -------------------------------------------------------------------
  bit pending[3];
  bit req[3];
  bit stall_prev, lock_prev, last01;
  int stall_owner;

  always @(posedge HCLK)
  begin
    bit fwd;
    if (!HRESETn)
    begin
      pending    = '{0, 0, 0};
      stall_prev = 0;
      lock_prev  = 0;
      last01     = 0;
    end
    else
    begin
      for (int i = 0; i < 3; i++)
        req[i] = pending[i] || (hsel_s[i] && hreadyout_s[i]
                 && htrans_s[i] == ahb_mux_pkg::trans_nonseq);
      if (stall_prev)
        check(3, "hmaster", hmaster, stall_owner);
      // Only port 0 ever locks the bus
      if (lock_prev)
        check(5, "hmaster", hmaster, ahb_mux_pkg::master_0);
      if (!stall_prev && !lock_prev && req[2])
        check(3, "hmaster", hmaster, ahb_mux_pkg::master_2);
      else if (!stall_prev && !lock_prev && req[0] && req[1])
        check(4, "hmaster", hmaster, last01 ? ahb_mux_pkg::master_0
                                            : ahb_mux_pkg::master_1);
      // A request is buffered until its grant meets slave ready
      for (int i = 0; i < 3; i++)
      begin
        fwd        = (int'(hmaster) == i) && hreadyout_m;
        pending[i] = req[i] && !fwd;
      end
      stall_prev  = hsel_m && htrans_m[1] && !hready_m;
      stall_owner = int'(hmaster);
      if (hready_m)
      begin
        lock_prev = hsel_m && hmastlock_m;
        if (hmaster == ahb_mux_pkg::master_0)
          last01 = 0;
        else if (hmaster == ahb_mux_pkg::master_1)
          last01 = 1;
      end
    end
  end

  // Run limit
  always @(posedge HCLK)
  begin
    cycle++;
    if (cycle > max_cycle)
    begin
      $display("Timeout: traffic did not finish within %0d cycles", max_cycle);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic check_idle_state();
    check(0, "hsel_m", hsel_m, 1'b0);
    check(0, "hmaster", hmaster, ahb_mux_pkg::master_none);
    for (int i = 0; i < 3; i++)
    begin
      check(0, $sformatf("hreadyout_s%0d", i), hreadyout_s[i], 1'b1);
      check(0, $sformatf("hresp_s%0d", i), hresp_s[i], 1'b0);
    end
  endtask

  // -------------------------------------------------------------------
  // Test sequence
  // -------------------------------------------------------------------
  initial
  begin
    int failed;
    int errors;
    seed = 32'h292d_598e;
    test_name = '{"reset_state", "write_path", "read_path", "port2_priority",
                  "round_robin", "locked_sequence"};
    HCLK        = 1'b0;
    HRESETn     = 1'b0;
    cycle       = 0;
    hreadyout_m = 1'b1;
    hresp_m     = 1'b0;
    hrdata_m    = 32'd0;
    for (int i = 0; i < 3; i++)
    begin
      hsel_s[i]      = 1'b0;
      haddr_s[i]     = 32'd0;
      htrans_s[i]    = ahb_mux_pkg::trans_idle;
      hsize_s[i]     = 3'd2;
      hwrite_s[i]    = 1'b0;
      hmastlock_s[i] = 1'b0;
      hwdata_s[i]    = 32'd0;
    end
    for (int a = 0; a < 256; a++)
      mem[a] = 32'h5a5a_0000 ^ (a * 32'h0101_0101);
    repeat (8) @(posedge HCLK);
    check_idle_state();
    repeat (8) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;
    @(posedge HCLK);
    check_idle_state();
    $display("test %s done: %0d checks, %0d errors", test_name[0], chk_cnt[0],
             err_cnt[0]);
    fork
      run_master(0);
      run_master(1);
      run_master(2);
    join
    repeat (4) @(posedge HCLK);
    if (wr_q.size() != 0)
    begin
      err_cnt[1]++;
      $display("%0d issued writes never reached the slave", wr_q.size());
    end
    failed = 0;
    errors = 0;
    for (int t = 1; t < 6; t++)
    begin
      if (chk_cnt[t] == 0)
      begin
        err_cnt[t]++;
        $display("Test %s never saw a cycle to check", test_name[t]);
      end
      $display("test %s done: %0d checks, %0d errors", test_name[t], chk_cnt[t],
               err_cnt[t]);
    end
    for (int t = 0; t < 6; t++)
    begin
      errors += err_cnt[t];
      if (err_cnt[t] != 0)
        failed++;
    end
    $display("summary: %0d of 6 tests passed, %0d errors", 6 - failed, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== files.f ====
hdl/ahb_mux_pkg.sv
hdl/ahb_input_stage.sv
hdl/ahb_arbiter.sv
hdl/ahb_bus_mux.sv
hdl/ahb_master_mux.sv
bench/tb_ahb_master_mux.sv

// ==== hdl/ahb_arbiter.sv ====
/* AHB master multiplexer arbiter
   Fixed priority for port 2, round robin for ports 0 and 1 */
`timescale 1ns/1ps

module ahb_arbiter (
  input  logic                              HCLK,
  input  logic                              HRESETn,
  input  logic [ahb_mux_pkg::num_ports-1:0] req,
  // Address phase as seen on the slave side
  input  logic                              mux_sel,
  input  logic [1:0]                        mux_trans,
  input  logic                              mux_lock,
  input  logic                              mux_ready,
  input  logic                              hreadyout_m,
  output ahb_mux_pkg::grant_t               addr_grant,
  output ahb_mux_pkg::grant_t               data_grant,
  output logic                              data_active
);

  logic                stall_now;
  logic                stall_reg;
  logic                lock_now;
  logic                lock_reg;
  logic                rr_reg;
  logic                next_rr;
  ahb_mux_pkg::grant_t last_grant;

  // -------------------------------------------------------------------
  // Grant retention
  // -------------------------------------------------------------------
  // Transfer announced while HREADY low, must stay on the bus
  assign stall_now = mux_sel & mux_trans[1] & ~mux_ready;
  // Locked address phase, sampled only when accepted
  assign lock_now  = mux_sel & mux_lock;

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      stall_reg  <= 1'b0;
      last_grant <= '0;
    end
    else
    begin
      stall_reg  <= stall_now;
      last_grant <= addr_grant;
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      lock_reg <= 1'b0;
    else if (mux_ready)
      lock_reg <= lock_now;
  end

  // -------------------------------------------------------------------
  // Round robin state between ports 0 and 1
  // -------------------------------------------------------------------
  // Set when port 1 wins, cleared when port 0 wins
  // Unchanged while port 2 or nobody owns the bus
  assign next_rr = addr_grant[1] | (rr_reg & ~addr_grant[0]);

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      rr_reg <= 1'b0;
    else if (mux_ready)
      rr_reg <= next_rr;
  end

  // -------------------------------------------------------------------
  // Address phase grant
  // -------------------------------------------------------------------
  always_comb
  begin
    if (stall_reg | lock_reg)
      addr_grant = last_grant;
    else if (req[2])
      addr_grant = 3'b100;
    else if (req[1:0] == 2'b11)
      // Port not chosen last goes next
      addr_grant = {1'b0, ~rr_reg, rr_reg};
    else
      addr_grant = req;
  end

  // -------------------------------------------------------------------
  // Data phase tracking
  // -------------------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      data_grant  <= '0;
      data_active <= 1'b0;
    end
    else if (mux_ready)
    begin
      data_grant  <= addr_grant;
      data_active <= mux_sel & mux_trans[1];
    end
  end

  assert property (@(posedge HCLK) disable iff (!HRESETn)
    $onehot0(addr_grant) && $onehot0(data_grant));

  // Slave wait state always reaches the bus HREADY
  assert property (@(posedge HCLK) disable iff (!HRESETn)
    !hreadyout_m |-> !mux_ready);

endmodule

// ==== hdl/ahb_bus_mux.sv ====
/* AHB master multiplexer datapath
   Selects address, control and write data and drives HREADY to the slave */
`timescale 1ns/1ps

module ahb_bus_mux #(
  parameter int data_width = 32
) (
  input  ahb_mux_pkg::grant_t             addr_grant,
  input  ahb_mux_pkg::grant_t             data_grant,
  input  logic                            data_active,
  // Port 0
  input  logic                            ips_sel_s0,
  input  logic [ahb_mux_pkg::addr_w-1:0]  ips_addr_s0,
  input  ahb_mux_pkg::htrans_t            ips_trans_s0,
  input  logic [ahb_mux_pkg::size_w-1:0]  ips_size_s0,
  input  logic                            ips_write_s0,
  input  logic                            ips_lock_s0,
  input  logic                            ips_ready_s0,
  input  logic [data_width-1:0]           hwdata_s0,
  // Port 1
  input  logic                            ips_sel_s1,
  input  logic [ahb_mux_pkg::addr_w-1:0]  ips_addr_s1,
  input  ahb_mux_pkg::htrans_t            ips_trans_s1,
  input  logic [ahb_mux_pkg::size_w-1:0]  ips_size_s1,
  input  logic                            ips_write_s1,
  input  logic                            ips_lock_s1,
  input  logic                            ips_ready_s1,
  input  logic [data_width-1:0]           hwdata_s1,
  // Port 2
  input  logic                            ips_sel_s2,
  input  logic [ahb_mux_pkg::addr_w-1:0]  ips_addr_s2,
  input  ahb_mux_pkg::htrans_t            ips_trans_s2,
  input  logic [ahb_mux_pkg::size_w-1:0]  ips_size_s2,
  input  logic                            ips_write_s2,
  input  logic                            ips_lock_s2,
  input  logic                            ips_ready_s2,
  input  logic [data_width-1:0]           hwdata_s2,
  input  logic                            hreadyout_m,
  // Slave side
  output logic                            hsel_m,
  output logic [ahb_mux_pkg::addr_w-1:0]  haddr_m,
  output ahb_mux_pkg::htrans_t            htrans_m,
  output logic [ahb_mux_pkg::size_w-1:0]  hsize_m,
  output logic                            hwrite_m,
  output logic                            hmastlock_m,
  output logic                            hready_m,
  output logic [data_width-1:0]           hwdata_m,
  output ahb_mux_pkg::hmaster_t           hmaster
);

  logic sel_ready;

  // -------------------------------------------------------------------
  // Address phase select
  // -------------------------------------------------------------------
  always_comb
  begin
    hsel_m      = 1'b0;
    haddr_m     = '0;
    htrans_m    = ahb_mux_pkg::trans_idle;
    hsize_m     = '0;
    hwrite_m    = 1'b0;
    hmastlock_m = 1'b0;
    // Nothing granted, bus is free to move
    sel_ready   = 1'b1;
    hmaster     = ahb_mux_pkg::master_none;
    case (addr_grant)
      3'b001:
      begin
        hsel_m      = ips_sel_s0;
        haddr_m     = ips_addr_s0;
        htrans_m    = ips_trans_s0;
        hsize_m     = ips_size_s0;
        hwrite_m    = ips_write_s0;
        hmastlock_m = ips_lock_s0;
        sel_ready   = ips_ready_s0;
        hmaster     = ahb_mux_pkg::master_0;
      end
      3'b010:
      begin
        hsel_m      = ips_sel_s1;
        haddr_m     = ips_addr_s1;
        htrans_m    = ips_trans_s1;
        hsize_m     = ips_size_s1;
        hwrite_m    = ips_write_s1;
        hmastlock_m = ips_lock_s1;
        sel_ready   = ips_ready_s1;
        hmaster     = ahb_mux_pkg::master_1;
      end
      3'b100:
      begin
        hsel_m      = ips_sel_s2;
        haddr_m     = ips_addr_s2;
        htrans_m    = ips_trans_s2;
        hsize_m     = ips_size_s2;
        hwrite_m    = ips_write_s2;
        hmastlock_m = ips_lock_s2;
        sel_ready   = ips_ready_s2;
        hmaster     = ahb_mux_pkg::master_2;
      end
      default:
      begin
        hsel_m = 1'b0;
      end
    endcase
  end

  // Slave owns HREADY during a real data phase
  assign hready_m = data_active ? hreadyout_m : sel_ready;

  // -------------------------------------------------------------------
  // Write data follows the data phase owner
  // -------------------------------------------------------------------
  always_comb
  begin
    case (data_grant)
      3'b001:  hwdata_m = hwdata_s0;
      3'b010:  hwdata_m = hwdata_s1;
      3'b100:  hwdata_m = hwdata_s2;
      default: hwdata_m = '0;
    endcase
  end

endmodule

// ==== hdl/ahb_input_stage.sv ====
/* AHB master port input stage
   Holds an address phase that cannot be forwarded and returns wait states */
`timescale 1ns/1ps

module ahb_input_stage #(
  parameter int data_width = 32
) (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  // Master side address phase
  input  logic                            hsel,
  input  logic [ahb_mux_pkg::addr_w-1:0]  haddr,
  input  ahb_mux_pkg::htrans_t            htrans,
  input  logic [ahb_mux_pkg::size_w-1:0]  hsize,
  input  logic                            hwrite,
  input  logic                            hready,
  input  logic                            hmastlock,
  // Grants for this port
  input  logic                            addr_grant_bit,
  input  logic                            data_grant_bit,
  // Slave response
  input  logic                            hreadyout_m,
  input  logic                            hresp_m,
  // Effective address phase towards the mux
  output logic                            req,
  output logic                            ips_sel,
  output logic [ahb_mux_pkg::addr_w-1:0]  ips_addr,
  output ahb_mux_pkg::htrans_t            ips_trans,
  output logic [ahb_mux_pkg::size_w-1:0]  ips_size,
  output logic                            ips_write,
  output logic                            ips_lock,
  output logic                            ips_ready,
  // Response back to the master
  output logic                            hreadyout,
  output logic                            hresp
);

  logic                           trans_valid;
  logic                           input_hold;
  logic                           hold_active;
  logic                           forwarded;
  logic [ahb_mux_pkg::addr_w-1:0] addr_reg;
  ahb_mux_pkg::htrans_t           trans_reg;
  logic [ahb_mux_pkg::size_w-1:0] size_reg;
  logic                           write_reg;
  logic                           lock_reg;

  // -------------------------------------------------------------------
  // Request detect and hold control
  // -------------------------------------------------------------------
  // NONSEQ or SEQ accepted from the master
  assign trans_valid = hsel & htrans[1] & hready;
  // Address phase goes out on the slave side this cycle
  assign forwarded   = addr_grant_bit & hreadyout_m;
  assign input_hold  = trans_valid & ~forwarded;
  assign req         = trans_valid | hold_active;

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      hold_active <= 1'b0;
    else
      hold_active <= input_hold | (hold_active & ~forwarded);
  end

  // Capture the address phase that lost arbitration
  always_ff @(posedge HCLK)
  begin
    if (input_hold)
    begin
      addr_reg  <= haddr;
      trans_reg <= htrans;
      size_reg  <= hsize;
      write_reg <= hwrite;
      lock_reg  <= hmastlock;
    end
  end

  // Buffered values replace the live bus while holding
  assign ips_sel   = hold_active | hsel;
  assign ips_addr  = hold_active ? addr_reg  : haddr;
  assign ips_trans = hold_active ? trans_reg : htrans;
  assign ips_size  = hold_active ? size_reg  : hsize;
  assign ips_write = hold_active ? write_reg : hwrite;
  assign ips_lock  = hold_active ? lock_reg  : hmastlock;
  assign ips_ready = hold_active | hready;

  // -------------------------------------------------------------------
  // Response return
  // -------------------------------------------------------------------
  // Wait while holding, slave ready only when this port owns the data phase
  assign hreadyout = ~hold_active & (data_grant_bit ? hreadyout_m : 1'b1);
  assign hresp     = data_grant_bit ? hresp_m : 1'b0;

  // Buffer only ever fills from a real request
  assert property (@(posedge HCLK) disable iff (!HRESETn)
    $rose(hold_active) |-> $past(trans_valid));

  // A transfer never asks for more than the data bus carries
  assert property (@(posedge HCLK) disable iff (!HRESETn)
    trans_valid |-> ((32'd8 << hsize) <= data_width));

endmodule

// ==== hdl/ahb_master_mux.sv ====
/* Three port AHB master multiplexer
   Lets three masters share one slave port with priority arbitration */
`timescale 1ns/1ps

module ahb_master_mux #(
  parameter int data_width = 32
) (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  // Master port 0
  input  logic                            hsel_s0,
  input  logic [ahb_mux_pkg::addr_w-1:0]  haddr_s0,
  input  ahb_mux_pkg::htrans_t            htrans_s0,
  input  logic [ahb_mux_pkg::size_w-1:0]  hsize_s0,
  input  logic                            hwrite_s0,
  input  logic                            hready_s0,
  input  logic                            hmastlock_s0,
  input  logic [data_width-1:0]           hwdata_s0,
  output logic                            hreadyout_s0,
  output logic                            hresp_s0,
  output logic [data_width-1:0]           hrdata_s0,
  // Master port 1
  input  logic                            hsel_s1,
  input  logic [ahb_mux_pkg::addr_w-1:0]  haddr_s1,
  input  ahb_mux_pkg::htrans_t            htrans_s1,
  input  logic [ahb_mux_pkg::size_w-1:0]  hsize_s1,
  input  logic                            hwrite_s1,
  input  logic                            hready_s1,
  input  logic                            hmastlock_s1,
  input  logic [data_width-1:0]           hwdata_s1,
  output logic                            hreadyout_s1,
  output logic                            hresp_s1,
  output logic [data_width-1:0]           hrdata_s1,
  // Master port 2, highest priority
  input  logic                            hsel_s2,
  input  logic [ahb_mux_pkg::addr_w-1:0]  haddr_s2,
  input  ahb_mux_pkg::htrans_t            htrans_s2,
  input  logic [ahb_mux_pkg::size_w-1:0]  hsize_s2,
  input  logic                            hwrite_s2,
  input  logic                            hready_s2,
  input  logic                            hmastlock_s2,
  input  logic [data_width-1:0]           hwdata_s2,
  output logic                            hreadyout_s2,
  output logic                            hresp_s2,
  output logic [data_width-1:0]           hrdata_s2,
  // Slave port
  output logic                            hsel_m,
  output logic [ahb_mux_pkg::addr_w-1:0]  haddr_m,
  output ahb_mux_pkg::htrans_t            htrans_m,
  output logic [ahb_mux_pkg::size_w-1:0]  hsize_m,
  output logic                            hwrite_m,
  output logic                            hready_m,
  output logic                            hmastlock_m,
  output logic [data_width-1:0]           hwdata_m,
  output ahb_mux_pkg::hmaster_t           hmaster,
  input  logic                            hreadyout_m,
  input  logic                            hresp_m,
  input  logic [data_width-1:0]           hrdata_m
);

  logic [ahb_mux_pkg::num_ports-1:0] req;
  ahb_mux_pkg::grant_t               addr_grant;
  ahb_mux_pkg::grant_t               data_grant;
  logic                              data_active;
  logic                              ips_sel_s0, ips_sel_s1, ips_sel_s2;
  logic [ahb_mux_pkg::addr_w-1:0]    ips_addr_s0, ips_addr_s1, ips_addr_s2;
  ahb_mux_pkg::htrans_t              ips_trans_s0, ips_trans_s1, ips_trans_s2;
  logic [ahb_mux_pkg::size_w-1:0]    ips_size_s0, ips_size_s1, ips_size_s2;
  logic                              ips_write_s0, ips_write_s1, ips_write_s2;
  logic                              ips_lock_s0, ips_lock_s1, ips_lock_s2;
  logic                              ips_ready_s0, ips_ready_s1, ips_ready_s2;

  // -------------------------------------------------------------------
  // Input stages, one per master
  // -------------------------------------------------------------------
  ahb_input_stage #(.data_width(data_width)) u_stage0 (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .hsel(hsel_s0), .haddr(haddr_s0), .htrans(htrans_s0), .hsize(hsize_s0),
    .hwrite(hwrite_s0), .hready(hready_s0), .hmastlock(hmastlock_s0),
    .addr_grant_bit(addr_grant[0]), .data_grant_bit(data_grant[0]),
    .hreadyout_m(hreadyout_m), .hresp_m(hresp_m), .req(req[0]),
    .ips_sel(ips_sel_s0), .ips_addr(ips_addr_s0), .ips_trans(ips_trans_s0),
    .ips_size(ips_size_s0), .ips_write(ips_write_s0), .ips_lock(ips_lock_s0),
    .ips_ready(ips_ready_s0), .hreadyout(hreadyout_s0), .hresp(hresp_s0)
  );

  ahb_input_stage #(.data_width(data_width)) u_stage1 (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .hsel(hsel_s1), .haddr(haddr_s1), .htrans(htrans_s1), .hsize(hsize_s1),
    .hwrite(hwrite_s1), .hready(hready_s1), .hmastlock(hmastlock_s1),
    .addr_grant_bit(addr_grant[1]), .data_grant_bit(data_grant[1]),
    .hreadyout_m(hreadyout_m), .hresp_m(hresp_m), .req(req[1]),
    .ips_sel(ips_sel_s1), .ips_addr(ips_addr_s1), .ips_trans(ips_trans_s1),
    .ips_size(ips_size_s1), .ips_write(ips_write_s1), .ips_lock(ips_lock_s1),
    .ips_ready(ips_ready_s1), .hreadyout(hreadyout_s1), .hresp(hresp_s1)
  );

  ahb_input_stage #(.data_width(data_width)) u_stage2 (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .hsel(hsel_s2), .haddr(haddr_s2), .htrans(htrans_s2), .hsize(hsize_s2),
    .hwrite(hwrite_s2), .hready(hready_s2), .hmastlock(hmastlock_s2),
    .addr_grant_bit(addr_grant[2]), .data_grant_bit(data_grant[2]),
    .hreadyout_m(hreadyout_m), .hresp_m(hresp_m), .req(req[2]),
    .ips_sel(ips_sel_s2), .ips_addr(ips_addr_s2), .ips_trans(ips_trans_s2),
    .ips_size(ips_size_s2), .ips_write(ips_write_s2), .ips_lock(ips_lock_s2),
    .ips_ready(ips_ready_s2), .hreadyout(hreadyout_s2), .hresp(hresp_s2)
  );

  // -------------------------------------------------------------------
  // Arbitration and slave side multiplexing
  // -------------------------------------------------------------------
  ahb_arbiter u_arbiter (
    .HCLK(HCLK), .HRESETn(HRESETn), .req(req),
    .mux_sel(hsel_m), .mux_trans(htrans_m), .mux_lock(hmastlock_m),
    .mux_ready(hready_m), .hreadyout_m(hreadyout_m),
    .addr_grant(addr_grant), .data_grant(data_grant), .data_active(data_active)
  );

  ahb_bus_mux #(.data_width(data_width)) u_bus_mux (
    .addr_grant(addr_grant), .data_grant(data_grant), .data_active(data_active),
    .ips_sel_s0(ips_sel_s0), .ips_addr_s0(ips_addr_s0), .ips_trans_s0(ips_trans_s0),
    .ips_size_s0(ips_size_s0), .ips_write_s0(ips_write_s0), .ips_lock_s0(ips_lock_s0),
    .ips_ready_s0(ips_ready_s0), .hwdata_s0(hwdata_s0),
    .ips_sel_s1(ips_sel_s1), .ips_addr_s1(ips_addr_s1), .ips_trans_s1(ips_trans_s1),
    .ips_size_s1(ips_size_s1), .ips_write_s1(ips_write_s1), .ips_lock_s1(ips_lock_s1),
    .ips_ready_s1(ips_ready_s1), .hwdata_s1(hwdata_s1),
    .ips_sel_s2(ips_sel_s2), .ips_addr_s2(ips_addr_s2), .ips_trans_s2(ips_trans_s2),
    .ips_size_s2(ips_size_s2), .ips_write_s2(ips_write_s2), .ips_lock_s2(ips_lock_s2),
    .ips_ready_s2(ips_ready_s2), .hwdata_s2(hwdata_s2), .hreadyout_m(hreadyout_m),
    .hsel_m(hsel_m), .haddr_m(haddr_m), .htrans_m(htrans_m), .hsize_m(hsize_m),
    .hwrite_m(hwrite_m), .hmastlock_m(hmastlock_m), .hready_m(hready_m),
    .hwdata_m(hwdata_m), .hmaster(hmaster)
  );

  // Read data goes to every master, response qualifies it
  assign hrdata_s0 = hrdata_m;
  assign hrdata_s1 = hrdata_m;
  assign hrdata_s2 = hrdata_m;

endmodule

// ==== hdl/ahb_mux_pkg.sv ====
/* AHB master multiplexer shared definitions
   Bus geometry, transfer types and port select encodings */
package ahb_mux_pkg;

  // -------------------------------------------------------------------
  // Bus geometry
  // -------------------------------------------------------------------
  localparam int addr_w    = 32;
  localparam int size_w    = 3;
  localparam int num_ports = 3;

  // -------------------------------------------------------------------
  // Encodings
  // -------------------------------------------------------------------
  // HTRANS as defined by AHB
  typedef enum logic [1:0] {
    trans_idle   = 2'b00,
    trans_busy   = 2'b01,
    trans_nonseq = 2'b10,
    trans_seq    = 2'b11
  } htrans_t;

  // Owner of the current address phase
  typedef enum logic [1:0] {
    master_0    = 2'b00,
    master_1    = 2'b01,
    master_2    = 2'b10,
    master_none = 2'b11
  } hmaster_t;

  // Port select, bit i is port i
  // All zeros when no port owns the bus
  typedef logic [num_ports-1:0] grant_t;

endpackage
